/* run.sh */
#!/usr/bin/env bash
# build the router testbench with Verilator, run it, and judge the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module router_tb \
    -Mdir "$BUILD_DIR" -o router_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/router_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* source/crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module crossbar (
    input  wire                       clk,
    input  wire                       reset,
    input  wire flit_pkg::flit_t      head_xpos,
    input  wire flit_pkg::flit_t      head_ypos,
    input  wire flit_pkg::flit_t      head_zpos,
    input  wire flit_pkg::flit_t      head_xneg,
    input  wire flit_pkg::flit_t      head_yneg,
    input  wire flit_pkg::flit_t      head_zneg,
    input  wire port_pkg::port_t      sel_xpos,
    input  wire port_pkg::port_t      sel_ypos,
    input  wire port_pkg::port_t      sel_zpos,
    input  wire port_pkg::port_t      sel_xneg,
    input  wire port_pkg::port_t      sel_yneg,
    input  wire port_pkg::port_t      sel_zneg,
    input  wire                       sel_xpos_valid,
    input  wire                       sel_ypos_valid,
    input  wire                       sel_zpos_valid,
    input  wire                       sel_xneg_valid,
    input  wire                       sel_yneg_valid,
    input  wire                       sel_zneg_valid,
    input  wire port_pkg::port_mask_t eject,
    output flit_pkg::flit_t           out_xpos,
    output flit_pkg::flit_t           out_ypos,
    output flit_pkg::flit_t           out_zpos,
    output flit_pkg::flit_t           out_xneg,
    output flit_pkg::flit_t           out_yneg,
    output flit_pkg::flit_t           out_zneg,
    output logic                      out_xpos_valid,
    output logic                      out_ypos_valid,
    output logic                      out_zpos_valid,
    output logic                      out_xneg_valid,
    output logic                      out_yneg_valid,
    output logic                      out_zneg_valid,
    output flit_pkg::flit_t           eject_xpos,
    output flit_pkg::flit_t           eject_ypos,
    output flit_pkg::flit_t           eject_zpos,
    output flit_pkg::flit_t           eject_xneg,
    output flit_pkg::flit_t           eject_yneg,
    output flit_pkg::flit_t           eject_zneg,
    output logic                      eject_xpos_valid,
    output logic                      eject_ypos_valid,
    output logic                      eject_zpos_valid,
    output logic                      eject_xneg_valid,
    output logic                      eject_yneg_valid,
    output logic                      eject_zneg_valid
);

    flit_pkg::flit_t      head [port_pkg::PORT_NUM];
    port_pkg::port_t      sel [port_pkg::PORT_NUM];
    port_pkg::port_mask_t sel_valid;
    flit_pkg::flit_t      out_q [port_pkg::PORT_NUM];
    flit_pkg::flit_t      eject_q [port_pkg::PORT_NUM];
    port_pkg::port_mask_t out_valid_q;
    port_pkg::port_mask_t eject_valid_q;

    assign head = '{head_xpos, head_ypos, head_zpos, head_xneg, head_yneg, head_zneg};
    assign sel = '{sel_xpos, sel_ypos, sel_zpos, sel_xneg, sel_yneg, sel_zneg};
    assign sel_valid = {sel_zneg_valid, sel_yneg_valid, sel_xneg_valid,
                        sel_zpos_valid, sel_ypos_valid, sel_xpos_valid};

    always_ff @(posedge clk) begin
        for (int i = 0; i < port_pkg::PORT_NUM; i++) begin
            if (sel_valid[i]) begin
                out_q[i] <= head[sel[i]];
            end
            // eject port i only ever carries input i
            if (eject[i]) begin
                eject_q[i] <= head[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= '0;
            eject_valid_q <= '0;
        end else begin
            out_valid_q <= sel_valid;
            eject_valid_q <= eject;
        end
    end

    assign out_xpos = out_q[0];
    assign out_ypos = out_q[1];
    assign out_zpos = out_q[2];
    assign out_xneg = out_q[3];
    assign out_yneg = out_q[4];
    assign out_zneg = out_q[5];
    assign {out_zneg_valid, out_yneg_valid, out_xneg_valid,
            out_zpos_valid, out_ypos_valid, out_xpos_valid} = out_valid_q;

    assign eject_xpos = eject_q[0];
    assign eject_ypos = eject_q[1];
    assign eject_zpos = eject_q[2];
    assign eject_xneg = eject_q[3];
    assign eject_yneg = eject_q[4];
    assign eject_zneg = eject_q[5];
    assign {eject_zneg_valid, eject_yneg_valid, eject_xneg_valid,
            eject_zpos_valid, eject_ypos_valid, eject_xpos_valid} = eject_valid_q;

endmodule

`default_nettype wire

/* source/flit_pkg.sv */
`default_nettype none

package flit_pkg;

    localparam int COORD_W = 4;
    localparam int PAYLOAD_W = 20;
    localparam int FLIT_W = 3 * COORD_W + PAYLOAD_W;

    // destination fields sit above the payload, x on top
    localparam int DEST_X_LSB = FLIT_W - COORD_W;
    localparam int DEST_Y_LSB = DEST_X_LSB - COORD_W;
    localparam int DEST_Z_LSB = DEST_Y_LSB - COORD_W;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [FLIT_W-1:0] flit_t;

endpackage

`default_nettype wire

/* source/input_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module input_queue #(
    parameter int queue_depth = 16
)(
    input  wire                  clk,
    input  wire                  reset,
    input  wire flit_pkg::flit_t in,
    input  wire                  write,
    input  wire                  pop,
    output flit_pkg::flit_t      head,
    output logic                 head_valid
);

    localparam int ptr_w = $clog2(queue_depth);

    flit_pkg::flit_t mem [queue_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             do_write;
    logic             do_pop;

    assign head_valid = count != '0;
    assign full = count == (ptr_w + 1)'(queue_depth);
    // flits arriving at a full queue are dropped
    assign do_write = write && !full;
    assign do_pop = pop && head_valid;
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/port_pkg.sv */
`default_nettype none

package port_pkg;

    localparam int PORT_NUM = 6;

    // bit i of a port mask belongs to the port with value i
    typedef enum logic [2:0] {
        PORT_XPOS  = 3'd0,
        PORT_YPOS  = 3'd1,
        PORT_ZPOS  = 3'd2,
        PORT_XNEG  = 3'd3,
        PORT_YNEG  = 3'd4,
        PORT_ZNEG  = 3'd5,
        PORT_LOCAL = 3'd6
    } port_t;

    typedef logic [PORT_NUM-1:0] port_mask_t;

endpackage

`default_nettype wire

/* source/route_comp.sv */
`timescale 1ns/1ps
`default_nettype none

module route_comp #(
    parameter flit_pkg::coord_t cur_x = '0,
    parameter flit_pkg::coord_t cur_y = '0,
    parameter flit_pkg::coord_t cur_z = '0
)(
    input  wire flit_pkg::flit_t head,
    output port_pkg::port_t      route
);

    flit_pkg::coord_t dest_x;
    flit_pkg::coord_t dest_y;
    flit_pkg::coord_t dest_z;

    assign dest_x = head[flit_pkg::DEST_X_LSB +: flit_pkg::COORD_W];
    assign dest_y = head[flit_pkg::DEST_Y_LSB +: flit_pkg::COORD_W];
    assign dest_z = head[flit_pkg::DEST_Z_LSB +: flit_pkg::COORD_W];

    // x first, then y, then z
    always_comb begin
        if (dest_x > cur_x) begin
            route = port_pkg::PORT_XPOS;
        end else if (dest_x < cur_x) begin
            route = port_pkg::PORT_XNEG;
        end else if (dest_y > cur_y) begin
            route = port_pkg::PORT_YPOS;
        end else if (dest_y < cur_y) begin
            route = port_pkg::PORT_YNEG;
        end else if (dest_z > cur_z) begin
            route = port_pkg::PORT_ZPOS;
        end else if (dest_z < cur_z) begin
            route = port_pkg::PORT_ZNEG;
        end else begin
            // arrived, hand to the kernel
            route = port_pkg::PORT_LOCAL;
        end
    end

endmodule

`default_nettype wire

/* source/router.sv */
`timescale 1ns/1ps
`default_nettype none

module router #(
    parameter flit_pkg::coord_t cur_x = '0,
    parameter flit_pkg::coord_t cur_y = '0,
    parameter flit_pkg::coord_t cur_z = '0,
    parameter int queue_depth = 16
)(
    input  wire                  clk,
    input  wire                  reset,
    // neighbour links in
    input  wire flit_pkg::flit_t in_xpos,
    input  wire flit_pkg::flit_t in_ypos,
    input  wire flit_pkg::flit_t in_zpos,
    input  wire flit_pkg::flit_t in_xneg,
    input  wire flit_pkg::flit_t in_yneg,
    input  wire flit_pkg::flit_t in_zneg,
    input  wire                  in_xpos_valid,
    input  wire                  in_ypos_valid,
    input  wire                  in_zpos_valid,
    input  wire                  in_xneg_valid,
    input  wire                  in_yneg_valid,
    input  wire                  in_zneg_valid,
    // neighbour links out
    output flit_pkg::flit_t      out_xpos,
    output flit_pkg::flit_t      out_ypos,
    output flit_pkg::flit_t      out_zpos,
    output flit_pkg::flit_t      out_xneg,
    output flit_pkg::flit_t      out_yneg,
    output flit_pkg::flit_t      out_zneg,
    output logic                 out_xpos_valid,
    output logic                 out_ypos_valid,
    output logic                 out_zpos_valid,
    output logic                 out_xneg_valid,
    output logic                 out_yneg_valid,
    output logic                 out_zneg_valid,
    // to the application kernel, one per input link
    output flit_pkg::flit_t      eject_xpos,
    output flit_pkg::flit_t      eject_ypos,
    output flit_pkg::flit_t      eject_zpos,
    output flit_pkg::flit_t      eject_xneg,
    output flit_pkg::flit_t      eject_yneg,
    output flit_pkg::flit_t      eject_zneg,
    output logic                 eject_xpos_valid,
    output logic                 eject_ypos_valid,
    output logic                 eject_zpos_valid,
    output logic                 eject_xneg_valid,
    output logic                 eject_yneg_valid,
    output logic                 eject_zneg_valid
);

    // index order follows port_t
    wire flit_pkg::flit_t [port_pkg::PORT_NUM-1:0] in_flit =
        {in_zneg, in_yneg, in_xneg, in_zpos, in_ypos, in_xpos};
    wire port_pkg::port_mask_t in_valid =
        {in_zneg_valid, in_yneg_valid, in_xneg_valid, in_zpos_valid, in_ypos_valid, in_xpos_valid};

    wire flit_pkg::flit_t      head [port_pkg::PORT_NUM];
    wire port_pkg::port_t      route [port_pkg::PORT_NUM];
    wire port_pkg::port_t      sel [port_pkg::PORT_NUM];
    wire port_pkg::port_mask_t sel_valid;
    wire port_pkg::port_mask_t head_valid;
    wire port_pkg::port_mask_t pop;
    wire port_pkg::port_mask_t eject;

    for (genvar i = 0; i < port_pkg::PORT_NUM; i++) begin : g_port
        input_queue #(
            .queue_depth(queue_depth)
        ) i_queue (
            .clk(clk),
            .reset(reset),
            .in(in_flit[i]),
            .write(in_valid[i]),
            .pop(pop[i]),
            .head(head[i]),
            .head_valid(head_valid[i])
        );

        route_comp #(
            .cur_x(cur_x),
            .cur_y(cur_y),
            .cur_z(cur_z)
        ) i_route (
            .head(head[i]),
            .route(route[i])
        );
    end

    switch_alloc i_alloc (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .route_xpos(route[0]),
        .route_ypos(route[1]),
        .route_zpos(route[2]),
        .route_xneg(route[3]),
        .route_yneg(route[4]),
        .route_zneg(route[5]),
        .pop(pop),
        .eject(eject),
        .sel_xpos(sel[0]),
        .sel_ypos(sel[1]),
        .sel_zpos(sel[2]),
        .sel_xneg(sel[3]),
        .sel_yneg(sel[4]),
        .sel_zneg(sel[5]),
        .sel_xpos_valid(sel_valid[0]),
        .sel_ypos_valid(sel_valid[1]),
        .sel_zpos_valid(sel_valid[2]),
        .sel_xneg_valid(sel_valid[3]),
        .sel_yneg_valid(sel_valid[4]),
        .sel_zneg_valid(sel_valid[5])
    );

    crossbar i_xbar (
        .clk(clk),
        .reset(reset),
        .head_xpos(head[0]),
        .head_ypos(head[1]),
        .head_zpos(head[2]),
        .head_xneg(head[3]),
        .head_yneg(head[4]),
        .head_zneg(head[5]),
        .sel_xpos(sel[0]),
        .sel_ypos(sel[1]),
        .sel_zpos(sel[2]),
        .sel_xneg(sel[3]),
        .sel_yneg(sel[4]),
        .sel_zneg(sel[5]),
        .sel_xpos_valid(sel_valid[0]),
        .sel_ypos_valid(sel_valid[1]),
        .sel_zpos_valid(sel_valid[2]),
        .sel_xneg_valid(sel_valid[3]),
        .sel_yneg_valid(sel_valid[4]),
        .sel_zneg_valid(sel_valid[5]),
        .eject(eject),
        .out_xpos(out_xpos),
        .out_ypos(out_ypos),
        .out_zpos(out_zpos),
        .out_xneg(out_xneg),
        .out_yneg(out_yneg),
        .out_zneg(out_zneg),
        .out_xpos_valid(out_xpos_valid),
        .out_ypos_valid(out_ypos_valid),
        .out_zpos_valid(out_zpos_valid),
        .out_xneg_valid(out_xneg_valid),
        .out_yneg_valid(out_yneg_valid),
        .out_zneg_valid(out_zneg_valid),
        .eject_xpos(eject_xpos),
        .eject_ypos(eject_ypos),
        .eject_zpos(eject_zpos),
        .eject_xneg(eject_xneg),
        .eject_yneg(eject_yneg),
        .eject_zneg(eject_zneg),
        .eject_xpos_valid(eject_xpos_valid),
        .eject_ypos_valid(eject_ypos_valid),
        .eject_zpos_valid(eject_zpos_valid),
        .eject_xneg_valid(eject_xneg_valid),
        .eject_yneg_valid(eject_yneg_valid),
        .eject_zneg_valid(eject_zneg_valid)
    );

endmodule

`default_nettype wire

/* source/switch_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_alloc (
    input  wire                       clk,
    input  wire                       reset,
    input  wire port_pkg::port_mask_t head_valid,
    input  wire port_pkg::port_t      route_xpos,
    input  wire port_pkg::port_t      route_ypos,
    input  wire port_pkg::port_t      route_zpos,
    input  wire port_pkg::port_t      route_xneg,
    input  wire port_pkg::port_t      route_yneg,
    input  wire port_pkg::port_t      route_zneg,
    output port_pkg::port_mask_t      pop,
    output port_pkg::port_mask_t      eject,
    output port_pkg::port_t           sel_xpos,
    output port_pkg::port_t           sel_ypos,
    output port_pkg::port_t           sel_zpos,
    output port_pkg::port_t           sel_xneg,
    output port_pkg::port_t           sel_yneg,
    output port_pkg::port_t           sel_zneg,
    output logic                      sel_xpos_valid,
    output logic                      sel_ypos_valid,
    output logic                      sel_zpos_valid,
    output logic                      sel_xneg_valid,
    output logic                      sel_yneg_valid,
    output logic                      sel_zneg_valid
);

    port_pkg::port_t      route [port_pkg::PORT_NUM];
    port_pkg::port_t      winner [port_pkg::PORT_NUM];
    port_pkg::port_t      ptr [port_pkg::PORT_NUM];
    port_pkg::port_mask_t found;
    port_pkg::port_mask_t grant;

    function automatic port_pkg::port_t next_port(input port_pkg::port_t p);
        if (p == port_pkg::PORT_ZNEG) begin
            return port_pkg::PORT_XPOS;
        end
        return port_pkg::port_t'(p + 3'd1);
    endfunction

    assign route = '{route_xpos, route_ypos, route_zpos, route_xneg, route_yneg, route_zneg};

    // per output, first requester at or after the pointer wins
    always_comb begin
        int idx;
        grant = '0;
        for (int o = 0; o < port_pkg::PORT_NUM; o++) begin
            found[o] = 1'b0;
            winner[o] = ptr[o];
            for (int k = 0; k < port_pkg::PORT_NUM; k++) begin
                idx = (int'(ptr[o]) + k) % port_pkg::PORT_NUM;
                if (!found[o] && head_valid[idx] && route[idx] == port_pkg::port_t'(o)) begin
                    found[o] = 1'b1;
                    winner[o] = port_pkg::port_t'(idx);
                end
            end
            if (found[o]) begin
                grant[winner[o]] = 1'b1;
            end
        end
    end

    // local heads never compete
    always_comb begin
        for (int i = 0; i < port_pkg::PORT_NUM; i++) begin
            eject[i] = head_valid[i] && route[i] == port_pkg::PORT_LOCAL;
        end
    end

    assign pop = grant | eject;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int o = 0; o < port_pkg::PORT_NUM; o++) begin
                ptr[o] <= port_pkg::PORT_XPOS;
            end
        end else begin
            // next search starts one past the winner
            for (int o = 0; o < port_pkg::PORT_NUM; o++) begin
                if (found[o]) begin
                    ptr[o] <= next_port(winner[o]);
                end
            end
        end
    end

    assign sel_xpos = winner[0];
    assign sel_ypos = winner[1];
    assign sel_zpos = winner[2];
    assign sel_xneg = winner[3];
    assign sel_yneg = winner[4];
    assign sel_zneg = winner[5];
    assign {sel_zneg_valid, sel_yneg_valid, sel_xneg_valid,
            sel_zpos_valid, sel_ypos_valid, sel_xpos_valid} = found;

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
source/flit_pkg.sv
source/port_pkg.sv
source/input_queue.sv
source/route_comp.sv
source/switch_alloc.sv
source/crossbar.sv
source/router.sv
test/router_tb.sv

/* test/router_model.svh */
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

// expected flits per source, one queue per output port
// slot PORT_LOCAL holds the flits owed to the eject port
flit_pkg::flit_t exp_q [port_pkg::PORT_NUM][port_pkg::PORT_NUM+1][$];

// target port of every flit a source still owes, oldest first
int src_route_q [port_pkg::PORT_NUM][$];

// x, then y, then z
// positive ports are 0 to 2 and negative ports 3 to 5, by dimension
function automatic int expected_port(input flit_pkg::flit_t f);
    int dest [3];
    int here [3];
    for (int d = 0; d < 3; d++) begin
        dest[d] = int'(f[flit_pkg::DEST_X_LSB - d * flit_pkg::COORD_W +: flit_pkg::COORD_W]);
    end
    here[0] = int'(NODE_X);
    here[1] = int'(NODE_Y);
    here[2] = int'(NODE_Z);
    for (int d = 0; d < 3; d++) begin
        if (dest[d] > here[d]) begin
            return d;
        end
        if (dest[d] < here[d]) begin
            return d + 3;
        end
    end
    return int'(port_pkg::PORT_LOCAL);
endfunction

task automatic push_expected(input int src, input int port, input flit_pkg::flit_t f);
    exp_q[src][port].push_back(f);
    src_route_q[src].push_back(port);
endtask

function automatic int pending_flits();
    int total;
    total = 0;
    for (int s = 0; s < port_pkg::PORT_NUM; s++) begin
        for (int p = 0; p <= port_pkg::PORT_NUM; p++) begin
            total += exp_q[s][p].size();
        end
    end
    return total;
endfunction

`endif

/* test/router_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module router_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 8;
    localparam int FLIT_NUM = 600;
    localparam int QUEUE_DEPTH = 16;
    localparam int DRAIN_LIMIT = 1000;
    localparam int WATCHDOG_CYCLES = FLIT_NUM * 20 + 200;
    localparam int LOCAL_PORT = int'(port_pkg::PORT_LOCAL);
    localparam flit_pkg::coord_t NODE_X = 4'd2;
    localparam flit_pkg::coord_t NODE_Y = 4'd2;
    localparam flit_pkg::coord_t NODE_Z = 4'd2;

    logic clk;
    logic reset;
    flit_pkg::flit_t in_flit [port_pkg::PORT_NUM];
    logic [port_pkg::PORT_NUM-1:0] in_valid;
    wire flit_pkg::flit_t out_flit [port_pkg::PORT_NUM];
    wire [port_pkg::PORT_NUM-1:0] out_valid;
    wire flit_pkg::flit_t eject_flit [port_pkg::PORT_NUM];
    wire [port_pkg::PORT_NUM-1:0] eject_valid;

    string dir_name [port_pkg::PORT_NUM] = '{"xpos", "ypos", "zpos", "xneg", "yneg", "zneg"};
    int seed = 32;
    int sent [port_pkg::PORT_NUM];
    int seen [port_pkg::PORT_NUM];
    int seq [port_pkg::PORT_NUM];
    // other-source flits on an output while a source's head waits for it
    int wait_count [port_pkg::PORT_NUM][port_pkg::PORT_NUM];
    int sent_total;
    int seen_total;
    int value_errors;
    int other_errors;

    `include "router_model.svh"

    router #(
        .cur_x(NODE_X),
        .cur_y(NODE_Y),
        .cur_z(NODE_Z),
        .queue_depth(QUEUE_DEPTH)
    ) i_dut (
        .clk(clk),
        .reset(reset),
        .in_xpos(in_flit[0]),
        .in_ypos(in_flit[1]),
        .in_zpos(in_flit[2]),
        .in_xneg(in_flit[3]),
        .in_yneg(in_flit[4]),
        .in_zneg(in_flit[5]),
        .in_xpos_valid(in_valid[0]),
        .in_ypos_valid(in_valid[1]),
        .in_zpos_valid(in_valid[2]),
        .in_xneg_valid(in_valid[3]),
        .in_yneg_valid(in_valid[4]),
        .in_zneg_valid(in_valid[5]),
        .out_xpos(out_flit[0]),
        .out_ypos(out_flit[1]),
        .out_zpos(out_flit[2]),
        .out_xneg(out_flit[3]),
        .out_yneg(out_flit[4]),
        .out_zneg(out_flit[5]),
        .out_xpos_valid(out_valid[0]),
        .out_ypos_valid(out_valid[1]),
        .out_zpos_valid(out_valid[2]),
        .out_xneg_valid(out_valid[3]),
        .out_yneg_valid(out_valid[4]),
        .out_zneg_valid(out_valid[5]),
        .eject_xpos(eject_flit[0]),
        .eject_ypos(eject_flit[1]),
        .eject_zpos(eject_flit[2]),
        .eject_xneg(eject_flit[3]),
        .eject_yneg(eject_flit[4]),
        .eject_zneg(eject_flit[5]),
        .eject_xpos_valid(eject_valid[0]),
        .eject_ypos_valid(eject_valid[1]),
        .eject_zpos_valid(eject_valid[2]),
        .eject_xneg_valid(eject_valid[3]),
        .eject_yneg_valid(eject_valid[4]),
        .eject_zneg_valid(eject_valid[5])
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles: %0d wrong values, %0d other failures, %0d of %0d flits",
                 WATCHDOG_CYCLES, value_errors, other_errors, seen_total, sent_total);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic int rand_coord();
        return int'($unsigned($random(seed)) % 5);
    endfunction

    // payload holds the sequence number above the 3-bit source index
    function automatic flit_pkg::flit_t build_flit(input int src, input int x, input int y,
                                                   input int z);
        flit_pkg::flit_t f;
        f = '0;
        f[flit_pkg::DEST_X_LSB +: flit_pkg::COORD_W] = flit_pkg::coord_t'(x);
        f[flit_pkg::DEST_Y_LSB +: flit_pkg::COORD_W] = flit_pkg::coord_t'(y);
        f[flit_pkg::DEST_Z_LSB +: flit_pkg::COORD_W] = flit_pkg::coord_t'(z);
        f[flit_pkg::PAYLOAD_W-1:3] = (flit_pkg::PAYLOAD_W - 3)'(seq[src]);
        f[2:0] = 3'(src);
        return f;
    endfunction

    task automatic send_flit(input int src, input flit_pkg::flit_t f, input int port);
        in_flit[src] = f;
        in_valid[src] = 1'b1;
        push_expected(src, port, f);
        seq[src]++;
        sent[src]++;
        sent_total++;
    endtask

    task automatic check_flit(input int port, input int link, input bit is_eject,
                              input flit_pkg::flit_t f);
        string name;
        int src;
        flit_pkg::flit_t expected;
        name = $sformatf("%s_%s", is_eject ? "eject" : "out", dir_name[link]);
        src = int'(f[2:0]);
        if (src >= port_pkg::PORT_NUM) begin
            other_errors++;
            $display("flit %h on %s at %0t has no valid source index", f, name, $time);
            return;
        end
        seen[src]++;
        seen_total++;
        if (is_eject && src != link) begin
            other_errors++;
            $display("flit from input %0d left on %s at %0t", src, name, $time);
        end
        if (exp_q[src][port].size() == 0) begin
            other_errors++;
            $display("unexpected flit %h from input %0d on %s at %0t", f, src, name, $time);
        end else begin
            expected = exp_q[src][port].pop_front();
            if (f !== expected) begin
                value_errors++;
                $display("error at %0t: %s = %h, expected %h", $time, name, f, expected);
            end
        end
        if (src_route_q[src].size() != 0) begin
            void'(src_route_q[src].pop_front());
        end
        if (!is_eject) begin
            if (wait_count[src][port] > port_pkg::PORT_NUM) begin
                other_errors++;
                $display("input %0d waited through %0d other grants on %s at %0t",
                         src, wait_count[src][port], name, $time);
            end
            wait_count[src][port] = 0;
        end
    endtask

    task automatic check_outputs();
        int src;
        // fairness counts use the queue heads from before this cycle
        for (int o = 0; o < port_pkg::PORT_NUM; o++) begin
            if (out_valid[o] === 1'b1) begin
                src = int'(out_flit[o][2:0]);
                for (int s = 0; s < port_pkg::PORT_NUM; s++) begin
                    if (s != src && src_route_q[s].size() != 0 && src_route_q[s][0] == o) begin
                        wait_count[s][o]++;
                    end
                end
            end
        end
        for (int o = 0; o < port_pkg::PORT_NUM; o++) begin
            if (out_valid[o] === 1'b1) begin
                check_flit(o, o, 1'b0, out_flit[o]);
            end
        end
        for (int e = 0; e < port_pkg::PORT_NUM; e++) begin
            if (eject_valid[e] === 1'b1) begin
                check_flit(LOCAL_PORT, e, 1'b1, eject_flit[e]);
            end
        end
    endtask

    // outputs are checked before the new inputs go out
    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
        in_valid = '0;
    endtask

    // one flit through an empty router, two edges expected
    task automatic directed_flit(input int src, input int x, input int y, input int z,
                                 input int port);
        flit_pkg::flit_t f;
        int start;
        int cycles;
        f = build_flit(src, x, y, z);
        if (expected_port(f) != port) begin
            other_errors++;
            $display("model routes %0d,%0d,%0d to port %0d, not %0d", x, y, z,
                     expected_port(f), port);
        end
        send_flit(src, f, port);
        start = seen_total;
        cycles = 0;
        while (seen_total == start && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        if (seen_total == start) begin
            other_errors++;
            $display("flit from input %0d to %0d,%0d,%0d never came out", src, x, y, z);
        end else if (cycles != 2) begin
            other_errors++;
            $display("flit from input %0d took %0d cycles instead of 2", src, cycles);
        end
    endtask

    initial begin
        flit_pkg::flit_t f;
        int random_sent;
        int drain;
        reset = 1'b1;
        in_valid = '0;
        for (int i = 0; i < port_pkg::PORT_NUM; i++) begin
            in_flit[i] = '0;
        end
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
        // idle router, any output flit is flagged as unexpected
        repeat (IDLE_CYCLES) next_cycle();

        directed_flit(0, 3, 0, 4, int'(port_pkg::PORT_XPOS));
        directed_flit(1, 0, 4, 1, int'(port_pkg::PORT_XNEG));
        directed_flit(2, 4, 2, 0, int'(port_pkg::PORT_XPOS));
        directed_flit(3, 2, 3, 0, int'(port_pkg::PORT_YPOS));
        directed_flit(4, 2, 0, 4, int'(port_pkg::PORT_YNEG));
        directed_flit(5, 2, 2, 4, int'(port_pkg::PORT_ZPOS));
        directed_flit(0, 2, 2, 0, int'(port_pkg::PORT_ZNEG));
        for (int s = 0; s < port_pkg::PORT_NUM; s++) begin
            directed_flit(s, 2, 2, 2, LOCAL_PORT);
        end

        // random traffic, a queue never holds more than its depth
        random_sent = 0;
        while (random_sent < FLIT_NUM) begin
            next_cycle();
            for (int s = 0; s < port_pkg::PORT_NUM; s++) begin
                if (random_sent < FLIT_NUM && sent[s] - seen[s] < QUEUE_DEPTH
                        && $random(seed) % 4 != 0) begin
                    f = build_flit(s, rand_coord(), rand_coord(), rand_coord());
                    send_flit(s, f, expected_port(f));
                    random_sent++;
                end
            end
        end

        drain = 0;
        while (seen_total < sent_total && drain < DRAIN_LIMIT) begin
            next_cycle();
            drain++;
        end
        repeat (IDLE_CYCLES) next_cycle();
        if (pending_flits() != 0) begin
            other_errors++;
            $display("%0d flits never arrived", pending_flits());
        end

        $display("errors: %0d wrong values, %0d other failures, %0d flits sent, %0d received",
                 value_errors, other_errors, sent_total, seen_total);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
